// File: Makefile
VERILATOR  ?= verilator
VFLAGS     ?= --binary --assert --timescale 1ns/1ps
LINT_FLAGS ?= --lint-only --timing --assert --timescale 1ns/1ps
TOP        ?= tb_cpu
FILELIST   ?= list.f
PASS_TEXT  := all tests passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir

// File: common/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    localparam int WORD_W = 32;
    localparam int REG_IDX_W = 3;
    localparam int IMM_W = 16;
    localparam int OPCODE_W = 6;

    typedef logic [WORD_W-1:0]    word_t;
    typedef logic [REG_IDX_W-1:0] reg_idx_t;
    typedef logic [IMM_W-1:0]     imm_t;
    typedef logic [OPCODE_W-1:0]  opcode_t;

    // instruction word layout, lowest bit of each field
    localparam int OPCODE_LSB = 0;
    localparam int SEL_A_LSB = 6;
    localparam int SEL_B_LSB = 9;
    localparam int SEL_W_LSB = 12;
    localparam int HIGH_LOW_BIT = 15;
    localparam int IMM_LSB = 16;

    localparam opcode_t OP_NOP   = 6'd0;
    localparam opcode_t OP_ADD   = 6'd1;
    localparam opcode_t OP_SUB   = 6'd2;
    localparam opcode_t OP_AND   = 6'd3;
    localparam opcode_t OP_OR    = 6'd4;
    localparam opcode_t OP_XOR   = 6'd5;
    localparam opcode_t OP_LDI   = 6'd6;
    localparam opcode_t OP_STORE = 6'd7;
    localparam opcode_t OP_LOAD  = 6'd8;
    localparam opcode_t OP_CMPEQ = 6'd9;
    localparam opcode_t OP_CMPLT = 6'd10;
    localparam opcode_t OP_BRF   = 6'd11;
    localparam opcode_t OP_JMP   = 6'd12;
    // every opcode between JMP and HALT behaves as a NOP
    localparam opcode_t OP_HALT  = 6'd63;

endpackage

`default_nettype wire

// File: common/reg_port_if.sv
`timescale 1ns/1ps
`default_nettype none

interface reg_port_if;
    import cpu_pkg::*;

    reg_idx_t sel_a;
    reg_idx_t sel_b;
    reg_idx_t sel_w;
    word_t    data_a;
    word_t    data_b;
    logic     flag_a;
    logic     reg_we;
    logic     flag_we;
    word_t    wr_data;
    logic     wr_flag;

    modport storage (
        input  sel_a, sel_b, sel_w, reg_we, flag_we, wr_data, wr_flag,
        output data_a, data_b, flag_a
    );

    modport control (
        output sel_a, sel_b, sel_w, reg_we, flag_we, wr_data, wr_flag,
        input  data_a, data_b, flag_a
    );

    // the ALU only sees the two operand words
    modport operands (
        input data_a, data_b
    );

endinterface

`default_nettype wire

// File: hdl/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
    reg_port_if.operands      rp,
    input  wire cpu_pkg::opcode_t opcode,
    input  wire               high_low,
    input  wire cpu_pkg::imm_t    imm,
    output cpu_pkg::word_t    result,
    output logic              flag
);
    import cpu_pkg::*;

    word_t a;
    word_t b;
    word_t ldi_value;
    logic  is_arith;

    assign a = rp.data_a;
    assign b = rp.data_b;

    // LDI high keeps the low half of a and puts imm on top
    always_comb
    begin
        if (high_low)
            ldi_value = {imm, a[IMM_W-1:0]};
        else
            ldi_value = word_t'(imm);
    end

    always_comb
    begin
        case (opcode)
            OP_ADD:
                result = a + b;
            OP_SUB:
                result = a - b;
            OP_AND:
                result = a & b;
            OP_OR:
                result = a | b;
            OP_XOR:
                result = a ^ b;
            OP_LDI:
                result = ldi_value;
            default:
                result = '0;
        endcase
    end

    assign is_arith = (opcode inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR});

    always_comb
    begin
        if (is_arith)
            flag = (result == '0);
        else if (opcode == OP_CMPEQ)
            flag = (a == b);
        else if (opcode == OP_CMPLT)
            // unsigned compare
            flag = (a < b);
        else
            flag = 1'b0;
    end

endmodule

`default_nettype wire

// File: hdl/cpu_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_sequencer (
    input  wire                  clock,
    input  wire                  rst,
    input  wire cpu_pkg::word_t  mem_rdata,
    input  wire cpu_pkg::word_t  pc,
    input  wire cpu_pkg::word_t  alu_result,
    input  wire                  alu_flag,
    output cpu_pkg::word_t       mem_addr,
    output cpu_pkg::word_t       mem_wdata,
    output logic                 mem_rd,
    output logic                 mem_wr,
    output logic                 halted,
    output logic                 pc_advance,
    output logic                 branch_taken,
    output cpu_pkg::opcode_t     opcode,
    output logic                 high_low,
    output cpu_pkg::imm_t        imm,
    reg_port_if.control          rp
);
    import cpu_pkg::*;

    typedef enum logic [2:0] {
        FETCH,
        LATCH,
        EXECUTE,
        WRITEBACK,
        HALTED
    } seq_state_t;

    seq_state_t state;
    seq_state_t next_state;
    word_t      ir;
    logic       in_wb;
    logic       is_arith;

    always_ff @(posedge clock)
    begin
        if (rst)
            state <= FETCH;
        else
            state <= next_state;
    end

    always_comb
    begin
        case (state)
            FETCH:     next_state = LATCH;
            LATCH:     next_state = EXECUTE;
            EXECUTE:   next_state = (opcode == OP_HALT) ? HALTED : WRITEBACK;
            WRITEBACK: next_state = FETCH;
            default:   next_state = HALTED;
        endcase
    end

    // fetched word arrives one cycle after the FETCH strobe
    always_ff @(posedge clock)
    begin
        if (state == LATCH)
            ir <= mem_rdata;
    end

    assign opcode   = ir[OPCODE_LSB +: OPCODE_W];
    assign rp.sel_a = ir[SEL_A_LSB +: REG_IDX_W];
    assign rp.sel_b = ir[SEL_B_LSB +: REG_IDX_W];
    assign rp.sel_w = ir[SEL_W_LSB +: REG_IDX_W];
    assign high_low = ir[HIGH_LOW_BIT];
    assign imm      = ir[IMM_LSB +: IMM_W];

    assign in_wb    = (state == WRITEBACK);
    assign is_arith = (opcode inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR});

    always_comb
    begin
        mem_rd   = 1'b0;
        mem_wr   = 1'b0;
        mem_addr = pc;
        if (state == FETCH)
            mem_rd = 1'b1;
        else if (state == EXECUTE && opcode == OP_STORE)
        begin
            mem_wr   = 1'b1;
            mem_addr = rp.data_b;
        end
        else if (state == EXECUTE && opcode == OP_LOAD)
        begin
            mem_rd   = 1'b1;
            mem_addr = rp.data_a;
        end
    end

    assign mem_wdata = rp.data_a;

    assign rp.reg_we  = in_wb && (is_arith || opcode == OP_LDI || opcode == OP_LOAD);
    assign rp.flag_we = in_wb && (is_arith || opcode == OP_CMPEQ || opcode == OP_CMPLT);
    // load data lands in the WRITEBACK cycle
    assign rp.wr_data = (opcode == OP_LOAD) ? mem_rdata : alu_result;
    assign rp.wr_flag = alu_flag;

    assign pc_advance   = in_wb;
    assign branch_taken = (opcode == OP_JMP) || (opcode == OP_BRF && rp.flag_a);
    assign halted       = (state == HALTED);

    a_strobe_exclusive: assert property (@(posedge clock) disable iff (rst)
        !(mem_rd && mem_wr));

    a_no_write_halted: assert property (@(posedge clock) disable iff (rst)
        halted |=> halted && !rp.reg_we && !rp.flag_we && !mem_rd && !mem_wr);

endmodule

`default_nettype wire

// File: hdl/cpu_top.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_top #(
    parameter cpu_pkg::word_t RESET_PC = '0
) (
    input  wire                  clock,
    input  wire                  rst,
    input  wire cpu_pkg::word_t  mem_rdata,
    output wire cpu_pkg::word_t  mem_addr,
    output wire cpu_pkg::word_t  mem_wdata,
    output wire                  mem_rd,
    output wire                  mem_wr,
    output wire                  halted
);
    import cpu_pkg::*;

    word_t   pc;
    word_t   alu_result;
    logic    alu_flag;
    logic    pc_advance;
    logic    branch_taken;
    opcode_t opcode;
    logic    high_low;
    imm_t    imm;

    reg_port_if rp ();

    cpu_sequencer i_sequencer (
        .clock        (clock),
        .rst          (rst),
        .mem_rdata    (mem_rdata),
        .pc           (pc),
        .alu_result   (alu_result),
        .alu_flag     (alu_flag),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata),
        .mem_rd       (mem_rd),
        .mem_wr       (mem_wr),
        .halted       (halted),
        .pc_advance   (pc_advance),
        .branch_taken (branch_taken),
        .opcode       (opcode),
        .high_low     (high_low),
        .imm          (imm),
        .rp           (rp.control)
    );

    reg_file i_reg_file (
        .clock (clock),
        .rst   (rst),
        .rp    (rp.storage)
    );

    alu i_alu (
        .rp       (rp.operands),
        .opcode   (opcode),
        .high_low (high_low),
        .imm      (imm),
        .result   (alu_result),
        .flag     (alu_flag)
    );

    // branch target is the immediate field
    pc_unit #(
        .RESET_PC (RESET_PC)
    ) i_pc (
        .clock        (clock),
        .rst          (rst),
        .advance      (pc_advance),
        .branch_taken (branch_taken),
        .target       (imm),
        .pc           (pc)
    );

endmodule

`default_nettype wire

// File: hdl/pc_unit.sv
`timescale 1ns/1ps
`default_nettype none

module pc_unit #(
    parameter cpu_pkg::word_t RESET_PC = '0
) (
    input  wire                 clock,
    input  wire                 rst,
    input  wire                 advance,
    input  wire                 branch_taken,
    input  wire cpu_pkg::imm_t  target,
    output cpu_pkg::word_t      pc
);
    import cpu_pkg::*;

    word_t pc_inc;
    word_t pc_next;

    // incrementer, one word per instruction
    assign pc_inc = pc + word_t'(1);

    always_comb
    begin
        if (branch_taken)
            pc_next = word_t'(target);
        else
            pc_next = pc_inc;
    end

    always_ff @(posedge clock)
    begin
        if (rst)
            pc <= RESET_PC;
        else if (advance)
            pc <= pc_next;
    end

    a_pc_hold: assert property (@(posedge clock) disable iff (rst)
        !advance |=> $stable(pc));

endmodule

`default_nettype wire

// File: list.f
+incdir+sim
common/cpu_pkg.sv
common/reg_port_if.sv
hdl/alu.sv
hdl/pc_unit.sv
regfile/reg_file.sv
hdl/cpu_sequencer.sv
hdl/cpu_top.sv
sim/tb_cpu.sv

// File: regfile/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  wire          clock,
    input  wire          rst,
    reg_port_if.storage  rp
);
    import cpu_pkg::*;

    localparam int NUM_REGS = 2 ** REG_IDX_W;

    word_t               regs [NUM_REGS];
    logic [NUM_REGS-1:0] flags;

    // a register and its flag are written independently
    always_ff @(posedge clock)
    begin
        if (rst)
        begin
            for (int i = 0; i < NUM_REGS; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (rp.reg_we)
        begin
            regs[rp.sel_w] <= rp.wr_data;
        end
    end

    always_ff @(posedge clock)
    begin
        if (rst)
            flags <= '0;
        else if (rp.flag_we)
            flags[rp.sel_w] <= rp.wr_flag;
    end

    // read ports are combinational
    assign rp.data_a = regs[rp.sel_a];
    assign rp.data_b = regs[rp.sel_b];
    assign rp.flag_a = flags[rp.sel_a];

    a_known_index: assert property (@(posedge clock) disable iff (rst)
        (rp.reg_we || rp.flag_we) |-> !$isunknown(rp.sel_w));

endmodule

`default_nettype wire

// File: sim/program_patterns.txt
// header: program length, expected store count, instruction budget
// then one program word per line from address 0, then expected store address and data
00000022 00000009 00000032
56781006 // 00 ldi r1 = 0x5678
12349046 // 01 ldi r1 high 0x1234
0F0F2006 // 02 ldi r2 = 0x0f0f
F0F0A086 // 03 ldi r2 high 0xf0f0
00807006 // 04 ldi r7 = 0x80
00003441 // 05 add r3 = r1 + r2
00000EC7 // 06 store r3 at r7
00003442 // 07 sub r3 = r1 - r2
00000EC7 // 08 store r3 at r7
00003443 // 09 and r3 = r1 & r2
00000EC7 // 0a store r3 at r7
00003444 // 0b or r3 = r1 | r2
00000EC7 // 0c store r3 at r7
00003445 // 0d xor r3 = r1 ^ r2
00000EC7 // 0e store r3 at r7
000041C8 // 0f load r4 from r7
00815006 // 10 ldi r5 = 0x81
00000B07 // 11 store r4 at r5
00006449 // 12 cmpeq f6 = r1 == r2, clear
0016018B // 13 brf f6 to 0x16, falls through
0000644A // 14 cmplt f6 = r1 < r2, set
0017018B // 15 brf f6 to 0x17, taken
00000E47 // 16 store r1 at r7, never reached
00016006 // 17 ldi r6 = 1
00035006 // 18 ldi r5 = 3
00907006 // 19 ldi r7 = 0x90
00000E07 // 1a loop: store r0 at r7
00000C01 // 1b add r0 = r0 + r6
00007DC1 // 1c add r7 = r7 + r6
00004A0A // 1d cmplt f4 = r0 < r5
001A010B // 1e brf f4 to 0x1a
0021000C // 1f jmp 0x21
00000E47 // 20 store r1 at r7, never reached
0000003F // 21 halt
00000080 03246587
00000080 21444769
00000080 10300608
00000080 F2F45F7F
00000080 E2C45977
00000081 E2C45977
00000090 00000000
00000091 00000001
00000092 00000002

// File: sim/tb_checks.svh
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// failures that have no expected value, such as a hang or a stray store
task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("tests failed");
    $fatal(1, "simulation stopped at first error");
endtask

task automatic check_word(input string name, input word_t got, input word_t expected);
    if (got !== expected)
    begin
        $display("Fail %s: got %h, expected %h", name, got, expected);
        $display("tests failed");
        $fatal(1, "simulation stopped at first error");
    end
endtask

task automatic check_bit(input string name, input logic got, input logic expected);
    if (got !== expected)
    begin
        $display("Fail %s: got %h, expected %h", name, got, expected);
        $display("tests failed");
        $fatal(1, "simulation stopped at first error");
    end
endtask

task automatic check_count(input string name, input int got, input int expected);
    if (got != expected)
    begin
        $display("Fail %s: got %h, expected %h", name, got, expected);
        $display("tests failed");
        $fatal(1, "simulation stopped at first error");
    end
endtask

`endif

// File: sim/tb_cpu.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cpu;
    import cpu_pkg::*;

    localparam word_t RESET_PC = '0;
    localparam int MEM_AW = 8;
    localparam int MEM_WORDS = 2 ** MEM_AW;
    localparam int PAT_AW = 6;
    localparam int PAT_WORDS = 2 ** PAT_AW;
    localparam int HEADER_WORDS = 3;

    logic  clock;
    logic  rst;
    word_t mem_rdata;
    word_t mem_addr;
    word_t mem_wdata;
    logic  mem_rd;
    logic  mem_wr;
    logic  halted;

    word_t mem [MEM_WORDS];
    word_t patterns [PAT_WORDS];
    word_t exp_addr [$];
    word_t exp_data [$];
    int    prog_len;
    int    exp_count;
    int    budget;
    int    timeout_limit = 0;
    int    cycle_count = 0;
    int    store_count = 0;

    `include "tb_checks.svh"

    cpu_top #(
        .RESET_PC (RESET_PC)
    ) i_dut (
        .clock     (clock),
        .rst       (rst),
        .mem_rdata (mem_rdata),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_rd    (mem_rd),
        .mem_wr    (mem_wr),
        .halted    (halted)
    );

    initial
    begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    function automatic word_t pattern_word(input int pos);
        return patterns[pos[PAT_AW-1:0]];
    endfunction

    // memory answers a read one cycle later, stores are checked in order
    always @(posedge clock)
    begin
        if (!rst && (mem_rd || mem_wr) && mem_addr >= MEM_WORDS)
            abort_run("memory access outside the 256-word model");
        if (mem_rd)
            mem_rdata <= mem[mem_addr[MEM_AW-1:0]];
        if (!rst && mem_wr)
        begin
            if (store_count >= exp_count)
                abort_run("unexpected store beyond the expected count");
            check_word("mem_addr", mem_addr, exp_addr[store_count]);
            check_word("mem_wdata", mem_wdata, exp_data[store_count]);
            mem[mem_addr[MEM_AW-1:0]] = mem_wdata;
            store_count <= store_count + 1;
        end
    end

    always @(posedge clock)
    begin
        cycle_count <= cycle_count + 1;
        if (timeout_limit > 0 && cycle_count >= timeout_limit)
            abort_run("timeout: the core did not halt within the cycle limit");
    end

    initial
    begin
        rst <= 1'b1;
        mem_rdata <= '0;
        $readmemh("sim/program_patterns.txt", patterns);
        if ($isunknown(patterns[0]) || $isunknown(patterns[1]) || $isunknown(patterns[2]))
            abort_run("pattern file is missing or has no header");
        prog_len  = patterns[0];
        exp_count = patterns[1];
        budget    = patterns[2];
        if (HEADER_WORDS + prog_len + 2 * exp_count > PAT_WORDS || prog_len > MEM_WORDS)
            abort_run("pattern file header does not fit the buffers");
        timeout_limit = 4 * budget + 20;

        // words outside the program carry their own address
        for (int i = 0; i < MEM_WORDS; i++)
            mem[i[MEM_AW-1:0]] = 32'hee00_0000 | word_t'(i);
        for (int i = 0; i < prog_len; i++)
            mem[i[MEM_AW-1:0]] = pattern_word(HEADER_WORDS + i);
        for (int k = 0; k < exp_count; k++)
        begin
            exp_addr.push_back(pattern_word(HEADER_WORDS + prog_len + 2 * k));
            exp_data.push_back(pattern_word(HEADER_WORDS + prog_len + 2 * k + 1));
        end

        repeat (5) @(posedge clock);
        rst <= 1'b0;

        // first cycle out of reset is the fetch from RESET_PC
        @(negedge clock);
        check_bit("mem_wr", mem_wr, 1'b0);
        check_bit("halted", halted, 1'b0);
        check_bit("mem_rd", mem_rd, 1'b1);
        check_word("mem_addr", mem_addr, RESET_PC);

        while (halted !== 1'b1)
            @(negedge clock);

        // a halted core stays off the memory bus
        repeat (8)
        begin
            @(negedge clock);
            check_bit("mem_rd", mem_rd, 1'b0);
            check_bit("mem_wr", mem_wr, 1'b0);
            check_bit("halted", halted, 1'b1);
        end

        if (store_count != exp_count)
            check_count("store_count", store_count, exp_count);
        else
        begin
            $display("all tests passed");
            $finish;
        end
    end

endmodule

`default_nettype wire
